//--- verilog/core_pkg.sv
// core package: shared widths, RV32I opcode and funct encodings, ALU ops, instruction views
package core_pkg;

  ////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////
  localparam int XLEN       = 32;                      // data and address width
  localparam int REG_ADDR_W = 5;                       // register index
  localparam int NUM_REGS   = 32;
  localparam int FIFO_DEPTH = 2;                       // buffer entries, also fetch credit
  localparam int PTR_W      = $clog2(FIFO_DEPTH);      // circular pointer
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);  // occupancy 0..FIFO_DEPTH

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;

  localparam logic [2:0] F3_ADD  = 3'b000;  // also SUB
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA by funct7
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

  // alu operations, LUI just passes operand b
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_LUI
  } alu_op_t;

  ////////////////////////////////////////
  // instruction word views
  ////////////////////////////////////////
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm12;   // shamt plus funct7 for shift immediates
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0]           imm20;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } instr_u;

  // wrap-around increment for the circular pointers
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    return nxt;
  endfunction

endpackage

//--- verilog/fetch_unit.sv
// fetch unit: sequential instruction requests under a credit limit, in-order PC tracking
module fetch_unit (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [core_pkg::XLEN-1:0]    boot_addr_i,
  input  logic                         fetch_enable_i,
  input  logic [core_pkg::CNT_W-1:0]   fifo_count_i,   // entries already buffered
  output logic                         instr_req_o,
  input  logic                         instr_gnt_i,
  output logic [core_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                         instr_rvalid_i,
  output logic                         push_o,
  output logic [core_pkg::XLEN-1:0]    push_pc_o
);

  logic                        boot_sel_q;   // first request still pending
  logic [core_pkg::XLEN-1:0]   pc_q;         // next fetch address after boot
  logic [core_pkg::CNT_W-1:0]  out_cnt_q;    // requests granted, no rvalid yet
  logic [core_pkg::CNT_W:0]    credit_used;  // one bit wider, no wrap
  logic                        grant;

  // granted PCs waiting for their response
  logic [core_pkg::XLEN-1:0]   pcq_mem [core_pkg::FIFO_DEPTH];
  logic [core_pkg::PTR_W-1:0]  pcq_wptr_q;
  logic [core_pkg::PTR_W-1:0]  pcq_rptr_q;

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////
  assign credit_used  = {1'b0, out_cnt_q} + {1'b0, fifo_count_i};
  assign instr_req_o  = fetch_enable_i &&
                        (credit_used < (core_pkg::CNT_W + 1)'(core_pkg::FIFO_DEPTH));
  assign instr_addr_o = boot_sel_q ? boot_addr_i : pc_q;  // addr only moves on grant
  assign grant        = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      boot_sel_q <= 1'b1;
      pc_q       <= '0;
    end
    else if (grant)
    begin
      boot_sel_q <= 1'b0;
      pc_q       <= instr_addr_o + core_pkg::XLEN'(4);  // sequential only
    end
  end

  // in-flight count, grant and rvalid may coincide
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_cnt_q <= '0;
    else
    begin
      case ({grant, instr_rvalid_i})
        2'b10:   out_cnt_q <= out_cnt_q + core_pkg::CNT_W'(1);
        2'b01:   out_cnt_q <= out_cnt_q - core_pkg::CNT_W'(1);
        default: ;  // none or both, count unchanged
      endcase
    end
  end

  ////////////////////////////////////////
  // PC queue
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pcq_wptr_q <= '0;
      pcq_rptr_q <= '0;
    end
    else
    begin
      if (grant)
        pcq_wptr_q <= core_pkg::ptr_inc(pcq_wptr_q);
      if (instr_rvalid_i)
        pcq_rptr_q <= core_pkg::ptr_inc(pcq_rptr_q);  // responses return in order
    end
  end

  always_ff @(posedge clk)
  begin
    if (grant)
      pcq_mem[pcq_wptr_q] <= instr_addr_o;
  end

  // response goes straight into the buffer with its PC
  assign push_o    = instr_rvalid_i;
  assign push_pc_o = pcq_mem[pcq_rptr_q];

  // waiting request keeps its address until granted
  addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> $stable(instr_addr_o));

  // memory never answers a request that was not granted
  no_spurious_rvalid_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> out_cnt_q != '0);

endmodule

//--- verilog/prefetch_fifo.sv
// prefetch buffer: circular FIFO of fetched instructions and their PCs
module prefetch_fifo (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         push_i,
  input  logic [core_pkg::XLEN-1:0]    push_instr_i,
  input  logic [core_pkg::XLEN-1:0]    push_pc_i,
  input  logic                         pop_i,
  output logic                         valid_o,
  output logic [core_pkg::XLEN-1:0]    head_instr_o,
  output logic [core_pkg::XLEN-1:0]    head_pc_o,
  output logic [core_pkg::CNT_W-1:0]   count_o
);

  logic [core_pkg::XLEN-1:0]   instr_mem [core_pkg::FIFO_DEPTH];
  logic [core_pkg::XLEN-1:0]   pc_mem    [core_pkg::FIFO_DEPTH];
  logic [core_pkg::PTR_W-1:0]  wptr_q;
  logic [core_pkg::PTR_W-1:0]  rptr_q;
  logic [core_pkg::CNT_W-1:0]  cnt_q;
  logic                        do_pop;

  assign do_pop  = pop_i && valid_o;  // entry leaves on valid and pop
  assign valid_o = (cnt_q != '0);
  assign count_o = cnt_q;

  // head is read straight from storage, visible the cycle after the push
  assign head_instr_o = instr_mem[rptr_q];
  assign head_pc_o    = pc_mem[rptr_q];

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end
    else
    begin
      if (push_i)
        wptr_q <= core_pkg::ptr_inc(wptr_q);
      if (do_pop)
        rptr_q <= core_pkg::ptr_inc(rptr_q);

      case ({push_i, do_pop})
        2'b10:   cnt_q <= cnt_q + core_pkg::CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - core_pkg::CNT_W'(1);
        default: ;  // push and pop together keep the count
      endcase
    end
  end

  // storage, written at the tail
  always_ff @(posedge clk)
  begin
    if (push_i)
    begin
      instr_mem[wptr_q] <= push_instr_i;
      pc_mem[wptr_q]    <= push_pc_i;
    end
  end

  // fetch credit must keep the buffer from overflowing
  no_push_full_a: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> cnt_q != core_pkg::CNT_W'(core_pkg::FIFO_DEPTH));

  // execute must only take what is there
  no_pop_empty_a: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> cnt_q != '0);

endmodule

//--- verilog/exec_unit.sv
// execute unit: RV32I subset decode, register file, ALU, writeback and commit report
module exec_unit (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              valid_i,
  input  core_pkg::instr_u                  instr_i,
  input  logic [core_pkg::XLEN-1:0]         pc_i,
  output logic                              pop_o,
  output logic                              commit_valid_o,
  output logic [core_pkg::XLEN-1:0]         commit_pc_o,
  output logic [core_pkg::REG_ADDR_W-1:0]   commit_rd_o,
  output logic [core_pkg::XLEN-1:0]         commit_wdata_o,
  output logic                              commit_illegal_o
);

  logic [core_pkg::XLEN-1:0]        rf [core_pkg::NUM_REGS];
  core_pkg::alu_op_t                alu_op;
  logic                             illegal;
  logic                             use_imm;   // OP-IMM, operand b from imm12
  logic                             is_lui;    // operand b from imm20
  logic [core_pkg::REG_ADDR_W-1:0]  rs1;
  logic [core_pkg::REG_ADDR_W-1:0]  rs2;
  logic [core_pkg::REG_ADDR_W-1:0]  rd;
  logic [core_pkg::XLEN-1:0]        op_a;
  logic [core_pkg::XLEN-1:0]        op_b;
  logic [core_pkg::XLEN-1:0]        rs2_val;
  logic [4:0]                       shamt;
  logic [core_pkg::XLEN-1:0]        result;
  logic                             rf_we;

  // single stage, take the head as soon as it shows up
  assign pop_o = valid_i;

  assign rs1 = instr_i.r.rs1;
  assign rs2 = instr_i.r.rs2;
  assign rd  = instr_i.r.rd;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  always_comb
  begin
    alu_op  = core_pkg::ALU_ADD;
    illegal = 1'b0;
    use_imm = 1'b0;
    is_lui  = 1'b0;
    case (instr_i.r.opcode)
      core_pkg::OPCODE_LUI:
      begin
        alu_op = core_pkg::ALU_LUI;
        is_lui = 1'b1;
      end
      core_pkg::OPCODE_OP_IMM:
      begin
        use_imm = 1'b1;
        case (instr_i.i.funct3)
          core_pkg::F3_ADD:  alu_op = core_pkg::ALU_ADD;
          core_pkg::F3_SLT:  alu_op = core_pkg::ALU_SLT;
          core_pkg::F3_SLTU: alu_op = core_pkg::ALU_SLTU;
          core_pkg::F3_XOR:  alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:   alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND:  alu_op = core_pkg::ALU_AND;
          // shift immediates: top of imm12 read as funct7
          core_pkg::F3_SLL:
          begin
            alu_op  = core_pkg::ALU_SLL;
            illegal = (instr_i.r.funct7 != core_pkg::F7_BASE);
          end
          default:  // F3_SR
          begin
            alu_op  = (instr_i.r.funct7 == core_pkg::F7_ALT) ? core_pkg::ALU_SRA
                                                              : core_pkg::ALU_SRL;
            illegal = (instr_i.r.funct7 != core_pkg::F7_BASE) &&
                      (instr_i.r.funct7 != core_pkg::F7_ALT);
          end
        endcase
      end
      core_pkg::OPCODE_OP:
      begin
        case (instr_i.r.funct3)
          core_pkg::F3_ADD:  alu_op = (instr_i.r.funct7 == core_pkg::F7_ALT) ? core_pkg::ALU_SUB
                                                                             : core_pkg::ALU_ADD;
          core_pkg::F3_SR:   alu_op = (instr_i.r.funct7 == core_pkg::F7_ALT) ? core_pkg::ALU_SRA
                                                                             : core_pkg::ALU_SRL;
          core_pkg::F3_SLL:  alu_op = core_pkg::ALU_SLL;
          core_pkg::F3_SLT:  alu_op = core_pkg::ALU_SLT;
          core_pkg::F3_SLTU: alu_op = core_pkg::ALU_SLTU;
          core_pkg::F3_XOR:  alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:   alu_op = core_pkg::ALU_OR;
          default:           alu_op = core_pkg::ALU_AND;
        endcase
        // only ADD and SR have an alternate form
        if (instr_i.r.funct3 == core_pkg::F3_ADD || instr_i.r.funct3 == core_pkg::F3_SR)
          illegal = (instr_i.r.funct7 != core_pkg::F7_BASE) &&
                    (instr_i.r.funct7 != core_pkg::F7_ALT);
        else
          illegal = (instr_i.r.funct7 != core_pkg::F7_BASE);
      end
      default: illegal = 1'b1;  // loads, stores, branches, system ...
    endcase
  end

  ////////////////////////////////////////
  // operands and ALU
  ////////////////////////////////////////
  assign op_a    = (rs1 == '0) ? '0 : rf[rs1];  // x0 reads zero
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

  always_comb
  begin
    if (is_lui)
      op_b = {instr_i.u.imm20, 12'b0};
    else if (use_imm)
      op_b = {{(core_pkg::XLEN - 12){instr_i.i.imm12[11]}}, instr_i.i.imm12};  // sign extend
    else
      op_b = rs2_val;
  end

  assign shamt = op_b[4:0];

  always_comb
  begin
    case (alu_op)
      core_pkg::ALU_ADD:  result = op_a + op_b;
      core_pkg::ALU_SUB:  result = op_a - op_b;
      core_pkg::ALU_SLL:  result = op_a << shamt;
      core_pkg::ALU_SLT:  result = {{(core_pkg::XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLTU: result = {{(core_pkg::XLEN - 1){1'b0}}, op_a < op_b};
      core_pkg::ALU_XOR:  result = op_a ^ op_b;
      core_pkg::ALU_SRL:  result = op_a >> shamt;
      core_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
      core_pkg::ALU_OR:   result = op_a | op_b;
      core_pkg::ALU_AND:  result = op_a & op_b;
      default:            result = op_b;  // LUI
    endcase
  end

  ////////////////////////////////////////
  // writeback and commit
  ////////////////////////////////////////
  assign rf_we = valid_i && !illegal && (rd != '0);

  // written at the pop edge, next instruction reads the new value
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++)
        rf[i] <= '0;
    end
    else if (rf_we)
      rf[rd] <= result;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      commit_valid_o   <= 1'b0;
      commit_illegal_o <= 1'b0;
    end
    else
    begin
      commit_valid_o   <= valid_i;
      commit_illegal_o <= valid_i && illegal;
    end
  end

  // x0 destination still reports the computed value
  always_ff @(posedge clk)
  begin
    if (valid_i)
    begin
      commit_pc_o    <= pc_i;
      commit_rd_o    <= illegal ? '0 : rd;
      commit_wdata_o <= illegal ? '0 : result;
    end
  end

  illegal_needs_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
    commit_illegal_o |-> commit_valid_o);

endmodule

//--- verilog/mini_core.sv
// core top: fetch unit, prefetch buffer and execute unit between memory and commit ports
module mini_core (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [core_pkg::XLEN-1:0]         boot_addr_i,
  input  logic                              fetch_enable_i,
  output logic                              instr_req_o,
  input  logic                              instr_gnt_i,
  output logic [core_pkg::XLEN-1:0]         instr_addr_o,
  input  logic                              instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]         instr_rdata_i,
  output logic                              commit_valid_o,
  output logic [core_pkg::XLEN-1:0]         commit_pc_o,
  output logic [core_pkg::REG_ADDR_W-1:0]   commit_rd_o,
  output logic [core_pkg::XLEN-1:0]         commit_wdata_o,
  output logic                              commit_illegal_o
);

  logic                         push;       // fetch -> buffer
  logic [core_pkg::XLEN-1:0]    push_pc;
  logic [core_pkg::CNT_W-1:0]   fifo_count; // buffer -> fetch credit
  logic                         fifo_valid; // buffer -> execute
  logic [core_pkg::XLEN-1:0]    head_instr;
  logic [core_pkg::XLEN-1:0]    head_pc;
  logic                         pop;        // execute -> buffer

  fetch_unit fetch_unit_inst (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .fifo_count_i   ( fifo_count     ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .push_o         ( push           ),
    .push_pc_o      ( push_pc        )
  );

  prefetch_fifo prefetch_fifo_inst (
    .clk          ( clk           ),
    .rst_n        ( rst_n         ),
    .push_i       ( push          ),
    .push_instr_i ( instr_rdata_i ), // response data goes in unregistered
    .push_pc_i    ( push_pc       ),
    .pop_i        ( pop           ),
    .valid_o      ( fifo_valid    ),
    .head_instr_o ( head_instr    ),
    .head_pc_o    ( head_pc       ),
    .count_o      ( fifo_count    )
  );

  exec_unit exec_unit_inst (
    .clk              ( clk              ),
    .rst_n            ( rst_n            ),
    .valid_i          ( fifo_valid       ),
    .instr_i          ( head_instr       ), // raw word seen as instr_u
    .pc_i             ( head_pc          ),
    .pop_o            ( pop              ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o )
  );

endmodule

//--- sim/commit_checker.sv
// commit checker: follows the fetch and commit ports of the core against the program table
module commit_checker #(
  parameter int NUM_ENTRIES = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] boot_addr_i,
  input  logic        fetch_enable_i,
  input  logic        instr_req_i,
  input  logic        instr_gnt_i,
  input  logic [31:0] instr_addr_i,
  input  logic        commit_valid_i,
  input  logic [31:0] commit_pc_i,
  input  logic [4:0]  commit_rd_i,
  input  logic [31:0] commit_wdata_i,
  input  logic        commit_illegal_i,
  input  logic [69:0] prog_tab_i [NUM_ENTRIES],  // {word, rd, value, illegal}
  output int          error_cnt_o,
  output int          commit_cnt_o,
  output logic        done_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IDX_W        = $clog2(NUM_ENTRIES);
  localparam int QUIET_CYCLES = 10;  // idle time after the last commit

  int          grant_idx;    // granted requests so far
  int          since_reset;
  int          quiet_cycles;
  logic [69:0] entry;

  task automatic compare_value(input string sig_name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("mismatch at %0d ns: %s expected %08h, got %08h",
               $time, sig_name, expected, actual);
      error_cnt_o++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("error at %0d ns: %s", $time, what);
    error_cnt_o++;
  endtask

  // commits in program order, pc follows the table index
  task automatic score_commit();
    logic [31:0] exp_pc;
    if (commit_cnt_o >= NUM_ENTRIES)
      report_failure("extra commit after the last program entry");
    else
    begin
      entry  = prog_tab_i[commit_cnt_o[IDX_W-1:0]];
      exp_pc = boot_addr_i + 32'(commit_cnt_o * 4);
      compare_value("commit_pc_o", exp_pc, commit_pc_i);
      compare_value("commit_rd_o", 32'(entry[37:33]), 32'(commit_rd_i));
      compare_value("commit_wdata_o", entry[32:1], commit_wdata_i);
      compare_value("commit_illegal_o", 32'(entry[0]), 32'(commit_illegal_i));
    end
    commit_cnt_o++;
  endtask

  ////////////////////////////////////////
  // per cycle checks at the rising edge
  ////////////////////////////////////////
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      since_reset = 0;
      done_o      = 1'b0;
      if (instr_req_i || commit_valid_i)
        report_failure("request or commit active during reset");
    end
    else
    begin
      if (since_reset == 0 && (instr_req_i || commit_valid_i))
        report_failure("request or commit active in the first cycle after reset");
      since_reset++;
      if (instr_req_i && !fetch_enable_i)
        report_failure("request raised while fetch enable is low");
      // sequential addresses from boot
      if (instr_req_i && instr_gnt_i)
      begin
        compare_value("instr_addr_o", boot_addr_i + 32'(grant_idx * 4), instr_addr_i);
        grant_idx++;
      end
      if (commit_valid_i)
        score_commit();
      else if (commit_cnt_o >= NUM_ENTRIES && !done_o)
      begin
        quiet_cycles++;  // no further commit allowed here
        if (quiet_cycles == QUIET_CYCLES)
          done_o = 1'b1;
      end
    end
  end

endmodule

//--- sim/tb_mini_core.sv
// core testbench: program table, instruction memory with grant stalls, enable gap and watchdog
module tb_mini_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_ENTRIES    = 29;
  localparam int          IDX_W          = $clog2(NUM_ENTRIES);
  localparam int          CLK_PERIOD     = 20;
  localparam int          RESET_CYCLES   = 16;
  localparam int          STALL_AT       = 12;  // grants before the enable gap
  localparam int          STALL_LEN      = 10;  // cycles with enable low
  localparam int          TIMEOUT_CYCLES = NUM_ENTRIES * 8 + RESET_CYCLES;
  localparam logic [31:0] BOOT_ADDR      = 32'h0000_1000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] boot_addr;
  logic        fetch_enable;
  logic        instr_req;
  logic        instr_gnt;
  logic [31:0] instr_addr;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic [4:0]  commit_rd;
  logic [31:0] commit_wdata;
  logic        commit_illegal;

  // row layout {instr word, rd, value, illegal}
  logic [69:0] prog_tab [NUM_ENTRIES];

  logic        gnt_seen;      // grant taken at the last rising edge
  logic [31:0] gnt_addr;
  int          gnt_cnt;
  logic [15:0] lfsr_state;
  int          cyc;
  int          stall_left;
  logic        stall_done;
  int          err_cnt;
  int          commit_cnt;
  logic        chk_done;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mini_core mini_core_inst (
    .clk              ( clk            ),
    .rst_n            ( rst_n          ),
    .boot_addr_i      ( boot_addr      ),
    .fetch_enable_i   ( fetch_enable   ),
    .instr_req_o      ( instr_req      ),
    .instr_gnt_i      ( instr_gnt      ),
    .instr_addr_o     ( instr_addr     ),
    .instr_rvalid_i   ( instr_rvalid   ),
    .instr_rdata_i    ( instr_rdata    ),
    .commit_valid_o   ( commit_valid   ),
    .commit_pc_o      ( commit_pc      ),
    .commit_rd_o      ( commit_rd      ),
    .commit_wdata_o   ( commit_wdata   ),
    .commit_illegal_o ( commit_illegal )
  );

  commit_checker #(.NUM_ENTRIES(NUM_ENTRIES)) commit_checker_inst (
    .clk              ( clk            ),
    .rst_n            ( rst_n          ),
    .boot_addr_i      ( boot_addr      ),
    .fetch_enable_i   ( fetch_enable   ),
    .instr_req_i      ( instr_req      ),
    .instr_gnt_i      ( instr_gnt      ),
    .instr_addr_i     ( instr_addr     ),
    .commit_valid_i   ( commit_valid   ),
    .commit_pc_i      ( commit_pc      ),
    .commit_rd_i      ( commit_rd      ),
    .commit_wdata_i   ( commit_wdata   ),
    .commit_illegal_i ( commit_illegal ),
    .prog_tab_i       ( prog_tab       ),
    .error_cnt_o      ( err_cnt        ),
    .commit_cnt_o     ( commit_cnt     ),
    .done_o           ( chk_done       )
  );

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  // memory contents, zero word past the program
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    int idx;
    idx = int'((addr - BOOT_ADDR) >> 2);
    if (idx >= 0 && idx < NUM_ENTRIES)
      return prog_tab[idx[IDX_W-1:0]][69:38];
    return 32'h0;
  endfunction

  ////////////////////////////////////////
  // program, expected values by hand
  ////////////////////////////////////////
  task automatic load_program();
    prog_tab[0]  = {32'h00500093, 5'd1,  32'h00000005, 1'b0};  // addi x1, x0, 5
    prog_tab[1]  = {32'hFFD00113, 5'd2,  32'hFFFFFFFD, 1'b0};  // addi x2, x0, -3
    prog_tab[2]  = {32'h800001B7, 5'd3,  32'h80000000, 1'b0};  // lui x3, 0x80000
    prog_tab[3]  = {32'h4041D213, 5'd4,  32'hF8000000, 1'b0};  // srai x4, x3, 4
    prog_tab[4]  = {32'h0041D293, 5'd5,  32'h08000000, 1'b0};  // srli x5, x3, 4
    prog_tab[5]  = {32'h00012313, 5'd6,  32'h00000001, 1'b0};  // slti x6, x2, 0
    prog_tab[6]  = {32'h00113393, 5'd7,  32'h00000000, 1'b0};  // sltiu x7, x2, 1
    prog_tab[7]  = {32'hFFF0C413, 5'd8,  32'hFFFFFFFA, 1'b0};  // xori x8, x1, -1
    prog_tab[8]  = {32'h0F00E493, 5'd9,  32'h000000F5, 1'b0};  // ori x9, x1, 0xf0
    prog_tab[9]  = {32'h07F17513, 5'd10, 32'h0000007D, 1'b0};  // andi x10, x2, 0x7f
    prog_tab[10] = {32'h00309593, 5'd11, 32'h00000028, 1'b0};  // slli x11, x1, 3
    prog_tab[11] = {32'h00208633, 5'd12, 32'h00000002, 1'b0};  // add x12, x1, x2
    prog_tab[12] = {32'h401606B3, 5'd13, 32'hFFFFFFFD, 1'b0};  // sub x13, x12, x1
    prog_tab[13] = {32'h0016A733, 5'd14, 32'h00000001, 1'b0};  // slt x14, x13, x1
    prog_tab[14] = {32'h0016B7B3, 5'd15, 32'h00000000, 1'b0};  // sltu x15, x13, x1
    prog_tab[15] = {32'h00B09833, 5'd16, 32'h00000500, 1'b0};  // sll x16, x1, x11
    prog_tab[16] = {32'h4011D8B3, 5'd17, 32'hFC000000, 1'b0};  // sra x17, x3, x1
    prog_tab[17] = {32'h0011D933, 5'd18, 32'h04000000, 1'b0};  // srl x18, x3, x1
    prog_tab[18] = {32'h009449B3, 5'd19, 32'hFFFFFF0F, 1'b0};  // xor x19, x8, x9
    prog_tab[19] = {32'h00B56A33, 5'd20, 32'h0000007D, 1'b0};  // or x20, x10, x11
    prog_tab[20] = {32'h00A9FAB3, 5'd21, 32'h0000000D, 1'b0};  // and x21, x19, x10
    prog_tab[21] = {32'h00708013, 5'd0,  32'h0000000C, 1'b0};  // addi x0, x1, 7
    prog_tab[22] = {32'h00100B33, 5'd22, 32'h00000005, 1'b0};  // add x22, x0, x1
    prog_tab[23] = {32'h00012083, 5'd0,  32'h00000000, 1'b1};  // lw x1, 0(x2)
    prog_tab[24] = {32'h00008B93, 5'd23, 32'h00000005, 1'b0};  // x1 untouched by lw
    prog_tab[25] = {32'h00000463, 5'd0,  32'h00000000, 1'b1};  // beq, rd field 8
    prog_tab[26] = {32'h00044C13, 5'd24, 32'hFFFFFFFA, 1'b0};  // x8 untouched by beq
    prog_tab[27] = {32'h02108CB3, 5'd0,  32'h00000000, 1'b1};  // mul x25, x1, x1
    prog_tab[28] = {32'h001C8D13, 5'd26, 32'h00000001, 1'b0};  // x25 still zero
  endtask

  // grants seen by the memory, answered one cycle later
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      gnt_seen <= 1'b0;
      gnt_cnt  <= 0;
    end
    else
    begin
      gnt_seen <= instr_req && instr_gnt;
      gnt_addr <= instr_addr;
      if (instr_req && instr_gnt)
        gnt_cnt <= gnt_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // stimulus, all inputs on the falling edge
  ////////////////////////////////////////
  initial
  begin
    rst_n        = 1'b0;
    boot_addr    = BOOT_ADDR;
    fetch_enable = 1'b0;  // low in reset, req is not gated by rst_n
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = 32'h0;
    lfsr_state   = 16'd8;
    cyc          = 0;
    stall_left   = 0;
    stall_done   = 1'b0;
    load_program();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    forever
    begin
      @(negedge clk);
      lfsr_state   = lfsr_step(lfsr_state);
      instr_gnt    = lfsr_state[0];  // random grant stalls
      instr_rvalid = gnt_seen;
      instr_rdata  = gnt_seen ? word_at(gnt_addr) : 32'h0;
      // enable gap once, mid program
      if (stall_left > 0)
        stall_left--;
      else if (!stall_done && gnt_cnt == STALL_AT)
      begin
        stall_left = STALL_LEN;
        stall_done = 1'b1;
      end
      cyc++;
      // stop fetching after the last entry was granted
      fetch_enable = (cyc > 2) && (stall_left == 0) && (gnt_cnt < NUM_ENTRIES);
    end
  end

  // end of run
  initial
  begin
    wait (chk_done === 1'b1);
    $display("closing counts: %0d errors, %0d of %0d commits", err_cnt, commit_cnt,
             NUM_ENTRIES);
    if (err_cnt == 0 && commit_cnt == NUM_ENTRIES)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: program did not finish within %0d cycles, %0d errors, %0d of %0d commits",
             TIMEOUT_CYCLES, err_cnt, commit_cnt, NUM_ENTRIES);
    $display("tests failed");
    $finish;
  end

endmodule

//--- flist.f
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/prefetch_fifo.sv
verilog/exec_unit.sv
verilog/mini_core.sv
sim/commit_checker.sv
sim/tb_mini_core.sv

//--- Makefile
SRCS := $(shell cat flist.f)

.PHONY: run clean

run: obj_dir/Vtb_mini_core
	@out=$$(./obj_dir/Vtb_mini_core); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

obj_dir/Vtb_mini_core: flist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f flist.f --top-module tb_mini_core -Mdir obj_dir

clean:
	rm -rf obj_dir
